// File: sim.f
logic/beam_pkg.sv
logic/beam_weighter.sv
logic/beam_fifo.sv
logic/beam_combiner.sv
logic/beamformer_top.sv
bench/beamformer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the beamformer testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module beamformer_tb -f sim.f -o beamformer_sim

status=0
./obj_dir/beamformer_sim > run.log 2>&1 || status=$?
cat run.log

if grep -q "Checks failed" run.log; then
    echo "simulation reported failing checks"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished without failures"

// File: bench/beamformer_tb.sv
// ----------------------------------------
// testbench for beamformer_top with fifo_depth 4
// stimulus is a 32-bit Fibonacci LFSR with a fixed seed
// expected beats come from reference functions and are checked in order
// the test 6 hold count assumes two weighter stages and one output register
// ----------------------------------------
`default_nettype none

module beamformer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH   = 4;
    localparam int N_SINGLE     = 16;
    localparam int N_RANDOM     = 200;
    localparam int N_LAST       = 100;
    localparam int N_STALL      = 16;
    localparam int STALL_CYCLES = 20;
    localparam int DRAIN_LIMIT  = 64;
    localparam int TOTAL_BEATS  = N_SINGLE + 2 * N_RANDOM + N_LAST + N_STALL;
    localparam int CYCLE_LIMIT  = 2 * TOTAL_BEATS + 200;

    logic                clock;
    logic                resetn;
    beam_pkg::in_beat_t  in_data;
    logic                in_valid;
    logic                in_ready;
    beam_pkg::out_beat_t out_data;
    logic                out_valid;
    logic                out_ready;

    beam_pkg::out_beat_t exp_q [$];
    beam_pkg::out_beat_t expected;
    logic [31:0]         lfsr_state = 32'hb86141cb;
    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  accepted_count = 0;
    int                  in_last_count = 0;
    int                  out_last_count = 0;
    int                  cycle_count;
    logic                single_mode;
    logic                in_ready_low_seen;

    beamformer_top #(
        .fifo_depth (FIFO_DEPTH)
    ) UUT (
        .clock     (clock),
        .resetn    (resetn),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #5 clock = ~clock;

    // taps 32, 22, 2 and 1; every bit handed out costs one step
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // kind 0 is fully random, kind 1 weights channel 0 only, kind 2 has sparse last flags
    function automatic beam_pkg::in_beat_t random_beat(input int kind);
        beam_pkg::in_beat_t b;
        logic [31:0]        bits;
        for (int c = 0; c < beam_pkg::NUM_CHANNELS; c++) begin
            for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
                bits = rand_bits(16);
                b.samples[c][k].re = bits[15:0];
                bits = rand_bits(16);
                b.samples[c][k].im = bits[15:0];
            end
            bits = rand_bits(8);
            b.weights[c].re = bits[7:0];
            bits = rand_bits(8);
            b.weights[c].im = bits[7:0];
        end
        if (kind == 2) begin
            bits = rand_bits(2);
            b.last = bits[1:0] == 2'b00;
        end else begin
            bits = rand_bits(1);
            b.last = bits[0];
        end
        if (kind == 1) begin
            b.weights = '0;
            b.weights[0].re = 8'h80;
            // the most negative sample has no positive twin, so its negation wraps
            b.samples[0][beam_pkg::NUM_LANES-1].im = 16'h8000;
        end
        return b;
    endfunction

    // full-precision products, shifted by the weight fraction bits, summed modulo 2^16
    // truncating each channel first gives the same low 16 bits as truncating the sum
    function automatic beam_pkg::out_beat_t expected_output(input beam_pkg::in_beat_t b);
        beam_pkg::out_beat_t o;
        int                  sum_re;
        int                  sum_im;
        int                  a_re;
        int                  a_im;
        int                  w_re;
        int                  w_im;
        o.last = b.last;
        for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
            sum_re = 0;
            sum_im = 0;
            for (int c = 0; c < beam_pkg::NUM_CHANNELS; c++) begin
                a_re = int'(b.samples[c][k].re);
                a_im = int'(b.samples[c][k].im);
                w_re = int'(b.weights[c].re);
                w_im = int'(b.weights[c].im);
                sum_re = sum_re + ((a_re * w_re - a_im * w_im) >>> beam_pkg::WEIGHT_FRAC_BITS);
                sum_im = sum_im + ((a_re * w_im + a_im * w_re) >>> beam_pkg::WEIGHT_FRAC_BITS);
            end
            o.lanes[k].re = sum_re[15:0];
            o.lanes[k].im = sum_im[15:0];
        end
        return o;
    endfunction

    // a weight of -1 on channel 0 alone should simply negate that channel
    function automatic beam_pkg::out_beat_t negated_channel0(input beam_pkg::in_beat_t b);
        beam_pkg::out_beat_t o;
        int                  v_re;
        int                  v_im;
        o.last = b.last;
        for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
            v_re = -int'(b.samples[0][k].re);
            v_im = -int'(b.samples[0][k].im);
            o.lanes[k].re = v_re[15:0];
            o.lanes[k].im = v_im[15:0];
        end
        return o;
    endfunction

    task automatic tally(input logic ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        assert (exp_v == got_v) else $display("ERR %s expected %h got %h", name, exp_v, got_v);
        tally(exp_v == got_v);
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("test %0d %s: %0d errors", num, name, fail_count - errors_before);
    endtask

    // ready_mode 0 is always ready, 1 is random, 2 stalls the sink for the first cycles
    task automatic stream(input int n, input int kind, input int ready_mode, input logic gaps);
        int base;
        int offered;
        int cycle;
        base = accepted_count;
        offered = 0;
        cycle = 0;
        while (accepted_count - base < n) begin
            @(negedge clock);
            if (ready_mode == 2 && cycle == STALL_CYCLES) begin
                // one beat in the output register, a full FIFO and both weighter stages
                check_value("held_beats", 32'(FIFO_DEPTH + 3), 32'(accepted_count - base));
            end
            case (ready_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = rand_bits(2) != 0;
                default: out_ready = cycle >= STALL_CYCLES;
            endcase
            if (!in_ready) begin
                in_ready_low_seen = 1'b1;
            end
            // a pending offer stays on the bus until the scoreboard has seen it taken
            if (!in_valid || accepted_count - base == offered) begin
                if (offered < n && (!gaps || rand_bits(2) != 0)) begin
                    in_data = random_beat(kind);
                    in_valid = 1'b1;
                    offered++;
                end else begin
                    in_valid = 1'b0;
                end
            end
            cycle++;
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic drain(input int ready_mode);
        int wait_cycles;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clock);
            out_ready = ready_mode == 1 ? (rand_bits(2) != 0) : 1'b1;
            wait_cycles++;
        end
        assert (exp_q.size() == 0) else $display("%0d expected beats never came out", exp_q.size());
        tally(exp_q.size() == 0);
    endtask

    // outputs are compared before inputs are recorded, the pipeline latency keeps them apart
    always @(posedge clock) begin
        if (resetn && out_valid && out_ready) begin
            if (out_data.last) begin
                out_last_count++;
            end
            assert (exp_q.size() != 0) else $display("output beat arrived with no beat expected");
            tally(exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                assert (out_data.lanes == expected.lanes) else
                    $display("ERR out_data expected %h got %h", expected.lanes, out_data.lanes);
                tally(out_data.lanes == expected.lanes);
                assert (out_data.last == expected.last) else
                    $display("ERR out_last expected %h got %h", expected.last, out_data.last);
                tally(out_data.last == expected.last);
            end
        end
        if (resetn && in_valid && in_ready) begin
            exp_q.push_back(single_mode ? negated_channel0(in_data) : expected_output(in_data));
            accepted_count++;
            if (in_data.last) begin
                in_last_count++;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int errors_before;
        int in_last_base;
        int out_last_base;
        clock = 1'b0;
        resetn = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        single_mode = 1'b0;
        in_ready_low_seen = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;

        errors_before = fail_count;
        @(negedge clock);
        check_value("out_valid", 32'h0, 32'(out_valid));
        check_value("in_ready", 32'h1, 32'(in_ready));
        report_test(1, "idle after reset", errors_before);

        errors_before = fail_count;
        single_mode = 1'b1;
        stream(N_SINGLE, 1, 0, 1'b0);
        drain(0);
        single_mode = 1'b0;
        report_test(2, "single channel negation", errors_before);

        errors_before = fail_count;
        stream(N_RANDOM, 0, 0, 1'b0);
        drain(0);
        report_test(3, "random beats, sink always ready", errors_before);

        errors_before = fail_count;
        stream(N_RANDOM, 0, 1, 1'b1);
        drain(1);
        report_test(4, "random beats with gaps and back-pressure", errors_before);

        errors_before = fail_count;
        in_last_base = in_last_count;
        out_last_base = out_last_count;
        stream(N_LAST, 2, 1, 1'b1);
        drain(1);
        check_value("last_count", 32'(in_last_count - in_last_base),
                    32'(out_last_count - out_last_base));
        report_test(5, "last flags", errors_before);

        errors_before = fail_count;
        in_ready_low_seen = 1'b0;
        stream(N_STALL, 0, 2, 1'b0);
        drain(0);
        assert (in_ready_low_seen) else $display("in_ready never dropped while the sink stalled");
        tally(in_ready_low_seen);
        report_test(6, "sink stall and release", errors_before);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/beamformer_top.sv
// ----------------------------------------
// four-channel narrowband beamformer
// every link is valid/ready and a beat moves when both are high
// without back-pressure the result of a beat is offered four edges
// after it was accepted, at one beat per cycle
// fifo_depth must be a power of two of at least 2
// ----------------------------------------
`default_nettype none

module beamformer_top #(
    parameter int fifo_depth = 4
) (
    input  wire logic                 clock,
    input  wire logic                 resetn,
    input  wire beam_pkg::in_beat_t   in_data,
    input  wire logic                 in_valid,
    output logic                      in_ready,
    output beam_pkg::out_beat_t       out_data,
    output logic                      out_valid,
    input  wire logic                 out_ready
);

    // weighter to FIFO
    beam_pkg::weighted_beat_t w_data;
    logic                     w_valid;
    logic                     w_ready;

    // FIFO to combiner
    beam_pkg::weighted_beat_t f_data;
    logic                     f_valid;
    logic                     f_ready;

    beam_weighter u_weighter (
        .clock    (clock),
        .resetn   (resetn),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .w_data   (w_data),
        .w_valid  (w_valid),
        .w_ready  (w_ready)
    );

    // the FIFO absorbs the two beats still in the weighter when the sink stalls
    beam_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clock   (clock),
        .resetn  (resetn),
        .w_data  (w_data),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .f_data  (f_data),
        .f_valid (f_valid),
        .f_ready (f_ready)
    );

    beam_combiner u_combiner (
        .clock     (clock),
        .resetn    (resetn),
        .f_data    (f_data),
        .f_valid   (f_valid),
        .f_ready   (f_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: logic/beam_combiner.sv
// ----------------------------------------
// sums the weighted channels lane by lane into one output stream
// real and imaginary parts are summed apart and wrap at 16 bits
// a single output register, held while the sink stalls
// ----------------------------------------
`default_nettype none

module beam_combiner (
    input  wire logic                      clock,
    input  wire logic                      resetn,
    input  wire beam_pkg::weighted_beat_t  f_data,
    input  wire logic                      f_valid,
    output logic                           f_ready,
    output beam_pkg::out_beat_t            out_data,
    output logic                           out_valid,
    input  wire logic                      out_ready
);

    beam_pkg::out_beat_t sum_next;
    logic                load;

    // the register can take a new beat when it is empty or being drained
    assign f_ready = !out_valid || out_ready;
    assign load    = f_valid && f_ready;

    // each partial sum is 16 bits wide, so overflow wraps the same way at every step
    always_comb begin
        sum_next.last = f_data.last;
        for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
            sum_next.lanes[k] = '0;
            for (int c = 0; c < beam_pkg::NUM_CHANNELS; c++) begin
                sum_next.lanes[k].re = sum_next.lanes[k].re + f_data.chan[c][k].re;
                sum_next.lanes[k].im = sum_next.lanes[k].im + f_data.chan[c][k].im;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (f_ready) begin
            out_valid <= f_valid;
        end
    end

    // last simply rides along with the sum of its beat
    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= sum_next;
        end
    end

    // a stalled sink must see the same beat until it accepts it
    a_out_hold: assert property (@(posedge clock) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: logic/beam_fifo.sv
// ----------------------------------------
// synchronous FIFO of weighted beats
// fifo_depth must be a power of two of at least 2
// the head is shown combinationally from the memory
// a write and a read may happen in the same cycle
// a full FIFO drops w_ready and takes no write even while it is read
// ----------------------------------------
`default_nettype none

module beam_fifo #(
    parameter int fifo_depth = 4
) (
    input  wire logic                      clock,
    input  wire logic                      resetn,
    input  wire beam_pkg::weighted_beat_t  w_data,
    input  wire logic                      w_valid,
    output logic                           w_ready,
    output beam_pkg::weighted_beat_t       f_data,
    output logic                           f_valid,
    input  wire logic                      f_ready
);

    localparam int PTR_W   = $clog2(fifo_depth);
    localparam int COUNT_W = PTR_W + 1;

    beam_pkg::weighted_beat_t mem [fifo_depth];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [COUNT_W-1:0]       count;
    logic                     wr_en;
    logic                     rd_en;

    assign w_ready = count != COUNT_W'(fifo_depth);
    assign f_valid = count != '0;
    assign f_data  = mem[rd_ptr];

    assign wr_en = w_valid && w_ready;
    assign rd_en = f_valid && f_ready;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= w_data;
        end
    end

    // the pointers wrap on their own because the depth is a power of two
    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the count must agree with the pointer distance and never pass the depth
    a_count_ok: assert property (@(posedge clock) disable iff (!resetn)
        count <= COUNT_W'(fifo_depth) && count[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr));

    // a read needs a stored beat, so the pointers differ unless the FIFO is full
    a_no_empty_read: assert property (@(posedge clock) disable iff (!resetn)
        rd_en |-> wr_ptr != rd_ptr || count == COUNT_W'(fifo_depth));

endmodule

`default_nettype wire

// File: logic/beam_weighter.sv
// ----------------------------------------
// two-stage complex weighting of all channels and lanes
// stage 1 holds the four partial products, stage 2 the scaled result
// the weights travel with each beat, so no weight state is kept
// the real and imaginary parts both use an arithmetic shift and keep
// the low 16 bits, so large products wrap rather than saturate
// ----------------------------------------
`default_nettype none

module beam_weighter (
    input  wire logic                      clock,
    input  wire logic                      resetn,
    input  wire beam_pkg::in_beat_t        in_data,
    input  wire logic                      in_valid,
    output logic                           in_ready,
    output beam_pkg::weighted_beat_t       w_data,
    output logic                           w_valid,
    input  wire logic                      w_ready
);

    // the four full-precision products of one complex multiply
    typedef struct packed {
        logic signed [beam_pkg::PROD_WIDTH-1:0] rr;
        logic signed [beam_pkg::PROD_WIDTH-1:0] ii;
        logic signed [beam_pkg::PROD_WIDTH-1:0] ri;
        logic signed [beam_pkg::PROD_WIDTH-1:0] ir;
    } part_prod_t;

    typedef part_prod_t [beam_pkg::NUM_CHANNELS-1:0][beam_pkg::NUM_LANES-1:0] prod_grid_t;

    logic                     advance;
    prod_grid_t               prod_next;
    prod_grid_t               s1_prod;
    logic                     s1_last;
    logic                     s1_valid;
    beam_pkg::weighted_beat_t w_next;

    // operands are sign extended to the product width by the assignment context
    function automatic part_prod_t multiply(beam_pkg::cplx_sample_t a,
                                            beam_pkg::cplx_weight_t w);
        part_prod_t p;
        p.rr = $signed(a.re) * $signed(w.re);
        p.ii = $signed(a.im) * $signed(w.im);
        p.ri = $signed(a.re) * $signed(w.im);
        p.ir = $signed(a.im) * $signed(w.re);
        return p;
    endfunction

    // combine the products, drop the weight fraction bits and keep 16 bits
    function automatic beam_pkg::cplx_sample_t scale(part_prod_t p);
        logic signed [beam_pkg::ACC_WIDTH-1:0] re_full;
        logic signed [beam_pkg::ACC_WIDTH-1:0] im_full;
        beam_pkg::cplx_sample_t                s;
        re_full = $signed(p.rr) - $signed(p.ii);
        im_full = $signed(p.ri) + $signed(p.ir);
        re_full = re_full >>> beam_pkg::WEIGHT_FRAC_BITS;
        im_full = im_full >>> beam_pkg::WEIGHT_FRAC_BITS;
        s.re = re_full[beam_pkg::SAMPLE_WIDTH-1:0];
        s.im = im_full[beam_pkg::SAMPLE_WIDTH-1:0];
        return s;
    endfunction

    // both stages move as one, whenever stage 2 is empty or is being drained
    assign advance  = !w_valid || w_ready;
    assign in_ready = advance;

    // every lane of a channel shares that channel's weight
    always_comb begin
        for (int c = 0; c < beam_pkg::NUM_CHANNELS; c++) begin
            for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
                prod_next[c][k] = multiply(in_data.samples[c][k], in_data.weights[c]);
            end
        end
    end

    always_comb begin
        w_next.last = s1_last;
        for (int c = 0; c < beam_pkg::NUM_CHANNELS; c++) begin
            for (int k = 0; k < beam_pkg::NUM_LANES; k++) begin
                w_next.chan[c][k] = scale(s1_prod[c][k]);
            end
        end
    end

    // a bubble in stage 1 moves into stage 2 as an empty slot
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            w_valid  <= s1_valid;
        end
    end

    // payload only loads for real beats, an idle pipe keeps its old contents
    always_ff @(posedge clock) begin
        if (advance && in_valid) begin
            s1_prod <= prod_next;
            s1_last <= in_data.last;
        end
        if (advance && s1_valid) begin
            w_data <= w_next;
        end
    end

    // a beat offered to the FIFO stays put until the FIFO takes it
    a_w_hold: assert property (@(posedge clock) disable iff (!resetn)
        w_valid && !w_ready |=> w_valid && $stable(w_data));

endmodule

`default_nettype wire

// File: logic/beam_pkg.sv
// ----------------------------------------
// types and fixed-point constants for the four-channel beamformer
// samples are signed 16-bit two's complement, re and im
// weights are signed Q1.7, range -1 to 127/128
// the lane count cannot be changed per instance
// ----------------------------------------
`default_nettype none

package beam_pkg;

    // antenna channels that are combined into one output stream
    localparam int NUM_CHANNELS = 4;

    // complex samples per channel carried in one beat
    localparam int NUM_LANES = 4;

    localparam int SAMPLE_WIDTH = 16;
    localparam int WEIGHT_WIDTH = 8;

    // a Q1.7 weight has seven fraction bits, so each product is shifted right by this much
    localparam int WEIGHT_FRAC_BITS = 7;

    // one sample times one weight needs the sum of both widths
    localparam int PROD_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH;

    // the difference or sum of two products needs one more bit before the shift
    localparam int ACC_WIDTH = PROD_WIDTH + 1;

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] re;
        logic signed [SAMPLE_WIDTH-1:0] im;
    } cplx_sample_t;

    typedef struct packed {
        logic signed [WEIGHT_WIDTH-1:0] re;
        logic signed [WEIGHT_WIDTH-1:0] im;
    } cplx_weight_t;

    // one channel's share of a beat, lane 0 in the low bits
    typedef cplx_sample_t [NUM_LANES-1:0] chan_lanes_t;

    // input beat, all channels arrive together with one weight each
    typedef struct packed {
        chan_lanes_t  [NUM_CHANNELS-1:0] samples;
        cplx_weight_t [NUM_CHANNELS-1:0] weights;
        logic                            last;
    } in_beat_t;

    // every channel already multiplied by its weight and scaled back to 16 bits
    typedef struct packed {
        chan_lanes_t [NUM_CHANNELS-1:0] chan;
        logic                           last;
    } weighted_beat_t;

    // the beamformed result, one complex sample per lane
    typedef struct packed {
        chan_lanes_t lanes;
        logic        last;
    } out_beat_t;

endpackage

`default_nettype wire
